// ==== hififo_pkg.sv ====
// shared vector types and packet constants for the host-bound bridge, imported by every rtl file
package hififo_pkg;

   // host address in qwords, so bits 63:3 of the byte address
   typedef logic [60:0] qword_addr_t;

   // buffer length in qwords
   typedef logic [19:0] qword_count_t;

   // producer word as stored in the fifo
   typedef logic [63:0] fifo_word_t;

   // one beat towards the pcie core, low dword goes out first
   typedef logic [63:0] tx_beat_t;

   // bus / device / function of this endpoint
   typedef logic [15:0] requester_id_t;

   // every memory write carries 128 bytes
   localparam int QWORDS_PER_PACKET = 16;

   // length field of each header, in dwords
   localparam int PAYLOAD_DWORDS = 32;

endpackage

// ==== hififo_fwft_fifo.sv ====
// dual-clock fall-through fifo, producer writes on i_wr_clock and the packet writer reads on clock
module hififo_fwft_fifo
  #(
   parameter int FIFO_DEPTH_LOG2 = 9
   )
  (
   input  logic                   clock,
   input  logic                   i_wr_clock,
   input  logic                   i_reset,
   input  logic                   i_write,
   input  hififo_pkg::fifo_word_t i_data,
   output logic                   o_ready,
   input  logic                   i_read,
   output hififo_pkg::fifo_word_t o_data,
   output logic                   o_almost_empty
   );
   import hififo_pkg::*;

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

   typedef logic [FIFO_DEPTH_LOG2:0] ptr_t; // extra msb tells full from empty

   fifo_word_t mem [DEPTH];

   // producer side
   logic [1:0] wr_reset_sync; // host reset carried into i_wr_clock
   logic       wr_reset;
   logic       wr_take;
   ptr_t       wr_bin;
   ptr_t       wr_bin_next;
   ptr_t       wr_gray;
   ptr_t       rd_gray_meta;
   ptr_t       rd_gray_sync;
   ptr_t       rd_bin_w;      // read pointer as the producer sees it
   ptr_t       wr_fill;

   // host side
   ptr_t       rd_bin;
   ptr_t       rd_bin_next;
   ptr_t       rd_gray;
   ptr_t       wr_gray_meta;
   ptr_t       wr_gray_sync;
   ptr_t       wr_bin_r;      // write pointer as the reader sees it
   ptr_t       rd_fill;

   function automatic ptr_t bin2gray(input ptr_t b);
      return b ^ (b >> 1);
   endfunction

   function automatic ptr_t gray2bin(input ptr_t g);
      ptr_t b;
      b[FIFO_DEPTH_LOG2] = g[FIFO_DEPTH_LOG2];
      for (int i = FIFO_DEPTH_LOG2 - 1; i >= 0; i--)
         b[i] = b[i+1] ^ g[i];
      return b;
   endfunction

   assign wr_reset = wr_reset_sync[1];
   assign rd_bin_w = gray2bin(rd_gray_sync);
   assign wr_fill = wr_bin - rd_bin_w;             // pessimistic, reader may be ahead
   assign o_ready = wr_fill != ptr_t'(DEPTH);
   assign wr_take = i_write && o_ready;
   assign wr_bin_next = wr_bin + ptr_t'(wr_take);

   always_ff @(posedge i_wr_clock)
   begin
      wr_reset_sync <= {wr_reset_sync[0], i_reset};
   end

   always_ff @(posedge i_wr_clock)
   begin
      if (wr_reset)
      begin
         wr_bin <= '0;
         wr_gray <= '0;
         rd_gray_meta <= '0;
         rd_gray_sync <= '0;
      end
      else
      begin
         wr_bin <= wr_bin_next;
         wr_gray <= bin2gray(wr_bin_next);   // only one bit moves per write
         rd_gray_meta <= rd_gray;
         rd_gray_sync <= rd_gray_meta;
      end
   end

   always_ff @(posedge i_wr_clock)
   begin
      if (wr_take)
         mem[wr_bin[FIFO_DEPTH_LOG2-1:0]] <= i_data;
   end

   assign wr_bin_r = gray2bin(wr_gray_sync);
   assign rd_fill = wr_bin_r - rd_bin;
   assign o_almost_empty = rd_fill < ptr_t'(QWORDS_PER_PACKET); // under one packet
   assign rd_bin_next = rd_bin + ptr_t'(i_read);

   always_ff @(posedge clock)
   begin
      if (i_reset)
      begin
         rd_bin <= '0;
         rd_gray <= '0;
         wr_gray_meta <= '0;
         wr_gray_sync <= '0;
      end
      else
      begin
         rd_bin <= rd_bin_next;
         rd_gray <= bin2gray(rd_bin_next);
         wr_gray_meta <= wr_gray;
         wr_gray_sync <= wr_gray_meta;
      end
   end

   // address runs one word ahead on a read, so the head word is always on o_data
   always_ff @(posedge clock)
   begin
      o_data <= mem[rd_bin_next[FIFO_DEPTH_LOG2-1:0]];
   end

   // the packet writer only reads words it saw through almost-empty
   a_no_read_empty: assert property (@(posedge clock) disable iff (i_reset)
      i_read |-> rd_fill != '0);

   // occupancy seen by the producer never passes the depth
   a_no_overfill: assert property (@(posedge i_wr_clock) disable iff (wr_reset)
      wr_fill <= ptr_t'(DEPTH));

endmodule

// ==== hififo_tpc_request.sv ====
// descriptor queue, collects host buffers from the register port and feeds the packet writer
module hififo_tpc_request
  #(
   parameter int DESC_DEPTH_LOG2 = 2
   )
  (
   input  logic                     clock,
   input  logic                     reset,
   input  logic                     i_desc_valid,
   input  hififo_pkg::qword_addr_t  i_desc_addr,
   input  hififo_pkg::qword_count_t i_desc_count,
   input  logic                     i_desc_interrupt,
   output logic                     o_desc_full,
   output logic                     o_req_valid,
   output hififo_pkg::qword_addr_t  o_req_addr,
   output hififo_pkg::qword_count_t o_req_count,
   output logic                     o_req_interrupt,
   input  logic                     i_req_take
   );
   import hififo_pkg::*;

   localparam int DEPTH = 1 << DESC_DEPTH_LOG2;

   typedef logic [DESC_DEPTH_LOG2-1:0] slot_t;
   typedef logic [DESC_DEPTH_LOG2:0]   level_t; // 0 .. DEPTH

   qword_addr_t      addr_mem [DEPTH];
   qword_count_t     count_mem [DEPTH];
   logic [DEPTH-1:0] irq_mem;         // interrupt flag per slot

   slot_t  wr_ptr;
   slot_t  rd_ptr;
   level_t level;
   logic   push;
   logic   pop;

   assign o_desc_full = level == level_t'(DEPTH);
   assign o_req_valid = level != '0;
   assign push = i_desc_valid && !o_desc_full;  // a pulse on a full queue is lost
   assign pop = i_req_take && o_req_valid;

   // head of queue straight from the slot
   assign o_req_addr = addr_mem[rd_ptr];
   assign o_req_count = count_mem[rd_ptr];
   assign o_req_interrupt = irq_mem[rd_ptr];

   always_ff @(posedge clock)
   begin
      if (push)
      begin
         addr_mem[wr_ptr] <= i_desc_addr;
         count_mem[wr_ptr] <= i_desc_count;
         irq_mem[wr_ptr] <= i_desc_interrupt;
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level <= '0;
      end
      else
      begin
         wr_ptr <= wr_ptr + slot_t'(push);    // wraps at DEPTH
         rd_ptr <= rd_ptr + slot_t'(pop);
         level <= level + level_t'(push) - level_t'(pop);
      end
   end

   // writer only handles whole 128-byte packets
   a_desc_count: assert property (@(posedge clock) disable iff (reset)
      i_desc_valid |-> (i_desc_count != '0) && ((i_desc_count % QWORDS_PER_PACKET) == 0));

   // host driver must watch o_desc_full
   a_desc_overflow: assert property (@(posedge clock) disable iff (reset)
      i_desc_valid |-> !o_desc_full);

endmodule

// ==== hififo_tpc_writer.sv ====
// memory-write packet builder, drains the fifo into 128-byte packets for the current host buffer
module hififo_tpc_writer
  (
   input  logic                      clock,
   input  logic                      reset,
   input  hififo_pkg::requester_id_t i_requester_id,
   // next buffer from the request queue
   input  logic                      i_req_valid,
   input  hififo_pkg::qword_addr_t   i_req_addr,
   input  hififo_pkg::qword_count_t  i_req_count,
   input  logic                      i_req_interrupt,
   output logic                      o_req_take,
   // fifo read side
   output logic                      o_fifo_read,
   input  hififo_pkg::fifo_word_t    i_fifo_data,
   input  logic                      i_fifo_almost_empty,
   // towards the pcie core
   output logic                      o_wr_valid,
   input  logic                      i_wr_ready,
   output hififo_pkg::tx_beat_t      o_wr_data,
   output logic                      o_wr_last,
   output logic                      o_wr_half,
   output logic                      o_interrupt,
   output logic [31:0]               o_status
   );
   import hififo_pkg::*;

   // what is on the bus right now
   typedef enum logic [1:0] {
      BEAT_IDLE,
      BEAT_HEADER,   // header offered, waits for i_wr_ready
      BEAT_ADDR,     // second header beat of a 4dw packet
      BEAT_PAYLOAD
   } beat_state_t;

   beat_state_t  state;
   qword_addr_t  addr;        // next qword to send
   qword_count_t count;       // qwords left in this buffer
   logic         irq_armed;
   logic         is_3dw;      // latched per packet, addr moves during payload
   logic [4:0]   pkt_reads;   // qwords pulled for this packet
   logic [31:0]  carry;       // odd dword held back in 3dw mode
   logic [63:0]  byte_addr;
   logic         addr_high;
   logic         start;
   logic [31:0]  hdr_dw0;
   logic [31:0]  hdr_dw1;

   // host is little endian, tlp payload goes out big endian per dword
   function automatic logic [31:0] swap32(input logic [31:0] x);
      return {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

   assign byte_addr = {addr, 3'b000};
   assign addr_high = byte_addr[63:32] != 32'd0;   // needs the 4dw format

   // fmt 10 or 11, type 00000 = memory write, tc / attr zero
   assign hdr_dw0 = {1'b0, 1'b1, addr_high, 19'd0, 10'(PAYLOAD_DWORDS)};
   assign hdr_dw1 = {i_requester_id, 8'h00, 8'hFF}; // tag 0, all byte enables

   assign o_req_take = i_req_valid && (state == BEAT_IDLE) && (count == '0);
   assign start = (state == BEAT_IDLE) && (count != '0) && !i_fifo_almost_empty;

   // 3dw takes q0 with the header accept, 4dw one beat later
   assign o_fifo_read = ((state == BEAT_HEADER) && i_wr_ready && is_3dw)
                        || (state == BEAT_ADDR)
                        || ((state == BEAT_PAYLOAD) && (pkt_reads != 5'(QWORDS_PER_PACKET)));

   assign o_status = {9'd0, count, 3'b000};   // bytes left

   // buffer bookkeeping
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         count <= '0;
         irq_armed <= 1'b0;
         o_interrupt <= 1'b0;
      end
      else
      begin
         o_interrupt <= irq_armed && (count == '0); // one clock after the last read
         if (o_req_take)
         begin
            count <= i_req_count;
            irq_armed <= i_req_interrupt;
         end
         else
         begin
            if (count == '0)
               irq_armed <= 1'b0;   // keeps the pulse to one clock
            if (o_fifo_read)
               count <= count - 1'b1;
         end
      end
      if (o_req_take)
         addr <= i_req_addr;
      else if (o_fifo_read)
         addr <= addr + 1'b1;
   end

   // beat sequencing
   // 3dw: hdr, addr+d0, 15 full beats, half beat = 18
   // 4dw: hdr, addr, 16 payload beats = 18
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state <= BEAT_IDLE;
         o_wr_valid <= 1'b0;
         o_wr_last <= 1'b0;
         o_wr_half <= 1'b0;
         is_3dw <= 1'b0;
         pkt_reads <= '0;
      end
      else
      begin
         case (state)
            BEAT_IDLE:
               if (start)
               begin
                  state <= BEAT_HEADER;
                  o_wr_valid <= 1'b1;
                  is_3dw <= !addr_high;
               end
            BEAT_HEADER:
               if (i_wr_ready)   // no ready checks after this
               begin
                  state <= is_3dw ? BEAT_PAYLOAD : BEAT_ADDR;
                  pkt_reads <= is_3dw ? 5'd1 : 5'd0;
               end
            BEAT_ADDR:
            begin
               state <= BEAT_PAYLOAD;
               pkt_reads <= 5'd1;
            end
            BEAT_PAYLOAD:
               if (o_wr_last)
               begin
                  state <= BEAT_IDLE;   // valid low for a clock between packets
                  o_wr_valid <= 1'b0;
                  o_wr_last <= 1'b0;
                  o_wr_half <= 1'b0;
               end
               else if (pkt_reads != 5'(QWORDS_PER_PACKET))
               begin
                  pkt_reads <= pkt_reads + 1'b1;
                  o_wr_last <= !is_3dw && (pkt_reads == 5'(QWORDS_PER_PACKET - 1));
               end
               else
               begin
                  o_wr_last <= 1'b1;   // 3dw leftover dword
                  o_wr_half <= 1'b1;
               end
            default:
               state <= BEAT_IDLE;
         endcase
      end
   end

   // beat data
   always_ff @(posedge clock)
   begin
      case (state)
         BEAT_IDLE:
            o_wr_data <= {hdr_dw1, hdr_dw0};   // dw0 in the low half
         BEAT_HEADER:
            if (i_wr_ready)
               o_wr_data <= is_3dw ? {swap32(i_fifo_data[31:0]), byte_addr[31:0]}
                                   : {byte_addr[31:0], byte_addr[63:32]};
         default:
            if (o_fifo_read)
               o_wr_data <= is_3dw ? {swap32(i_fifo_data[31:0]), carry}
                                   : {swap32(i_fifo_data[63:32]), swap32(i_fifo_data[31:0])};
            else
               o_wr_data <= {32'd0, carry};
      endcase
      if (o_fifo_read)
         carry <= swap32(i_fifo_data[63:32]);
   end

   // core expects an unbroken burst once the header is offered
   a_burst_valid: assert property (@(posedge clock) disable iff (reset)
      o_wr_valid && !o_wr_last |=> o_wr_valid);

endmodule

// ==== hififo_tpc_top.sv ====
// host-bound bridge top, ties descriptor queue, dual-clock fifo and packet writer together
module hififo_tpc_top
  #(
   parameter int FIFO_DEPTH_LOG2 = 9,
   parameter int DESC_DEPTH_LOG2 = 2
   )
  (
   input  logic                      clock,
   input  logic                      reset,
   input  hififo_pkg::requester_id_t i_requester_id,
   // producer domain
   input  logic                      i_fifo_clock,
   input  logic                      i_fifo_write,
   input  hififo_pkg::fifo_word_t    i_fifo_data,
   output logic                      o_fifo_ready,
   // descriptor port from the host driver
   input  logic                      i_desc_valid,
   input  hififo_pkg::qword_addr_t   i_desc_addr,
   input  hififo_pkg::qword_count_t  i_desc_count,
   input  logic                      i_desc_interrupt,
   output logic                      o_desc_full,
   // transmit side
   output logic                      o_wr_valid,
   input  logic                      i_wr_ready,
   output hififo_pkg::tx_beat_t      o_wr_data,
   output logic                      o_wr_last,
   output logic                      o_wr_half,
   output logic                      o_interrupt,
   output logic [31:0]               o_status
   );
   import hififo_pkg::*;

   logic         req_valid;
   qword_addr_t  req_addr;
   qword_count_t req_count;
   logic         req_interrupt;
   logic         req_take;
   logic         fifo_read;
   fifo_word_t   fifo_rdata;
   logic         fifo_almost_empty;

   hififo_tpc_request #(.DESC_DEPTH_LOG2(DESC_DEPTH_LOG2)) u_request
     (
      .clock(clock),
      .reset(reset),
      .i_desc_valid(i_desc_valid),
      .i_desc_addr(i_desc_addr),
      .i_desc_count(i_desc_count),
      .i_desc_interrupt(i_desc_interrupt),
      .o_desc_full(o_desc_full),
      .o_req_valid(req_valid),
      .o_req_addr(req_addr),
      .o_req_count(req_count),
      .o_req_interrupt(req_interrupt),
      .i_req_take(req_take)
      );

   hififo_fwft_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_fifo
     (
      .clock(clock),
      .i_wr_clock(i_fifo_clock),
      .i_reset(reset),
      .i_write(i_fifo_write),
      .i_data(i_fifo_data),
      .o_ready(o_fifo_ready),
      .i_read(fifo_read),
      .o_data(fifo_rdata),
      .o_almost_empty(fifo_almost_empty)
      );

   hififo_tpc_writer u_writer
     (
      .clock(clock),
      .reset(reset),
      .i_requester_id(i_requester_id),
      .i_req_valid(req_valid),
      .i_req_addr(req_addr),
      .i_req_count(req_count),
      .i_req_interrupt(req_interrupt),
      .o_req_take(req_take),
      .o_fifo_read(fifo_read),
      .i_fifo_data(fifo_rdata),
      .i_fifo_almost_empty(fifo_almost_empty),
      .o_wr_valid(o_wr_valid),
      .i_wr_ready(i_wr_ready),
      .o_wr_data(o_wr_data),
      .o_wr_last(o_wr_last),
      .o_wr_half(o_wr_half),
      .o_interrupt(o_interrupt),
      .o_status(o_status)
      );

endmodule

// ==== hififo_tpc_tb.sv ====
// testbench for the host-bound bridge, runs the packet tests and checks every beat against a model
module hififo_tpc_tb;
   import hififo_pkg::*;

   localparam int TOTAL_PACKETS = 21;                        // sum over all five tests
   localparam int CYCLE_LIMIT = 40 * 18 * TOTAL_PACKETS + 2000; // 18 beats per packet
   localparam requester_id_t RID = 16'hA35C;

   logic          clock;
   logic          reset;
   logic          i_fifo_clock;
   logic          i_fifo_write;
   fifo_word_t    i_fifo_data;
   logic          o_fifo_ready;
   logic          i_desc_valid;
   qword_addr_t   i_desc_addr;
   qword_count_t  i_desc_count;
   logic          i_desc_interrupt;
   logic          o_desc_full;
   logic          o_wr_valid;
   logic          i_wr_ready;
   tx_beat_t      o_wr_data;
   logic          o_wr_last;
   logic          o_wr_half;
   logic          o_interrupt;
   logic [31:0]   o_status;

   integer        seed;
   int            cycles;
   int            errors;
   int            tests;
   int            pkts_done;
   int            beat_idx;
   int            irq_count;
   int            test_err0;     // error count when the test began
   int            test_irq0;
   int            test_irq_exp;
   int            test_pkt0;
   bit            in_pkt;
   bit            offer_seen;
   bit            rand_ready;
   bit            saw_full;
   bit            irq_seen [0:63];
   string         test_name;

   fifo_word_t    words[$];       // producer stream in accept order
   qword_addr_t   exp_addr[$];    // one entry per expected packet
   qword_count_t  exp_remain[$];  // qwords left in the buffer before this packet
   bit            exp_irq[$];     // last packet of a flagged buffer

   hififo_tpc_top #(.FIFO_DEPTH_LOG2(6), .DESC_DEPTH_LOG2(2)) u_hififo_tpc_top
     (
      .clock(clock),
      .reset(reset),
      .i_requester_id(RID),
      .i_fifo_clock(i_fifo_clock),
      .i_fifo_write(i_fifo_write),
      .i_fifo_data(i_fifo_data),
      .o_fifo_ready(o_fifo_ready),
      .i_desc_valid(i_desc_valid),
      .i_desc_addr(i_desc_addr),
      .i_desc_count(i_desc_count),
      .i_desc_interrupt(i_desc_interrupt),
      .o_desc_full(o_desc_full),
      .o_wr_valid(o_wr_valid),
      .i_wr_ready(i_wr_ready),
      .o_wr_data(o_wr_data),
      .o_wr_last(o_wr_last),
      .o_wr_half(o_wr_half),
      .o_interrupt(o_interrupt),
      .o_status(o_status)
      );

   initial
   begin
      clock = 1'b0;
      forever #2 clock = ~clock;     // period 4
   end

   initial
   begin
      i_fifo_clock = 1'b0;
      forever #3 i_fifo_clock = ~i_fifo_clock;   // producer period 6
   end

   function automatic logic [31:0] byte_reverse(input logic [31:0] x);
      return {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

   // beat b of a packet at qword address a whose payload starts at word index w
   function automatic tx_beat_t expected_beat(input qword_addr_t a, input int w, input int b);
      logic [63:0] ba;
      logic        hi;
      ba = {a, 3'b000};
      hi = ba[63:32] != 32'd0;
      if (b == 0)
         return {RID, 8'h00, 8'hFF, 1'b0, 1'b1, hi, 19'd0, 10'd32};
      if (!hi)
      begin
         // 3dw, payload shifted up by one dword
         if (b == 1)
            return {byte_reverse(words[w][31:0]), ba[31:0]};
         if (b == 17)
            return {32'd0, byte_reverse(words[w+15][63:32])};
         return {byte_reverse(words[w+b-1][31:0]), byte_reverse(words[w+b-2][63:32])};
      end
      if (b == 1)
         return {ba[31:0], ba[63:32]};
      return {byte_reverse(words[w+b-2][63:32]), byte_reverse(words[w+b-2][31:0])};
   endfunction

   // transmit side, ready toggles only outside a burst
   always @(posedge clock)
   begin
      integer r;
      #1;
      r = $random(seed);
      if (!in_pkt)
         i_wr_ready = rand_ready ? (r[0] | r[1]) : 1'b1;
   end

   // producer inputs and ready are both settled at the falling edge
   always @(negedge i_fifo_clock)
   begin
      if (i_fifo_write && !o_fifo_ready)
         saw_full = 1'b1;
   end

   always @(posedge clock)
   begin
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("timeout after %0d cycles with %0d packets received", cycles, pkts_done);
         $display("Regression failed");
         $finish;
      end
   end

   // compares one beat of the current packet
   task automatic check_beat(input int b);
      tx_beat_t exp;
      bit       is3;
      is3 = {exp_addr[pkts_done], 3'b000} < 64'h1_0000_0000;
      exp = expected_beat(exp_addr[pkts_done], 16 * pkts_done, b);
      if (o_wr_data !== exp)
      begin
         $display("error %s pkt %0d beat %0d data expected %h actual %h",
                  test_name, pkts_done, b, exp, o_wr_data);
         errors++;
      end
      if (o_wr_last !== (b == 17))
      begin
         $display("error %s pkt %0d beat %0d last expected %0d actual %0d",
                  test_name, pkts_done, b, b == 17, o_wr_last);
         errors++;
      end
      if (o_wr_half !== (is3 && b == 17))
      begin
         $display("error %s pkt %0d beat %0d half expected %0d actual %0d",
                  test_name, pkts_done, b, is3 && b == 17, o_wr_half);
         errors++;
      end
   endtask

   // comparing process, samples mid-cycle where everything is settled
   always @(negedge clock)
   begin
      bit busy;      // a packet was already streaming at this sample
      if (!reset)
      begin
         busy = in_pkt;
         if (busy)
         begin
            if (!o_wr_valid)
            begin
               $display("valid dropped inside packet %0d in test %s", pkts_done, test_name);
               errors++;
               in_pkt = 0;
            end
            else
            begin
               check_beat(beat_idx);
               if (o_wr_last || beat_idx == 17)
               begin
                  if (o_status !== 32'(exp_remain[pkts_done] - 16) * 8)
                  begin
                     $display("error %s pkt %0d end status expected %0d actual %0d", test_name,
                              pkts_done, (exp_remain[pkts_done] - 16) * 8, o_status);
                     errors++;
                  end
                  pkts_done++;
                  in_pkt = 0;
               end
               beat_idx++;
            end
         end
         if (o_interrupt)
         begin
            if (pkts_done == 0 || !exp_irq[pkts_done-1] || irq_seen[pkts_done-1])
            begin
               $display("interrupt without a finished flagged buffer in test %s", test_name);
               errors++;
            end
            else
            begin
               irq_seen[pkts_done-1] = 1;
               irq_count++;
            end
         end
         if (!busy && o_wr_valid)
         begin
            if (pkts_done >= exp_addr.size())
            begin
               $display("unexpected packet offered in test %s", test_name);
               errors++;
               $display("Regression failed");
               $finish;
            end
            else
            begin
               if (!offer_seen && words.size() < 16 * pkts_done + 16)
               begin
                  $display("packet %0d offered with only %0d words written", pkts_done,
                           words.size());
                  errors++;
               end
               offer_seen = 1;
               if (i_wr_ready)    // header taken on the coming edge
               begin
                  check_beat(0);
                  if (o_status !== 32'(exp_remain[pkts_done]) * 8)
                  begin
                     $display("error %s pkt %0d status expected %0d actual %0d", test_name,
                              pkts_done, exp_remain[pkts_done] * 8, o_status);
                     errors++;
                  end
                  in_pkt = 1;
                  beat_idx = 1;
                  offer_seen = 0;
               end
            end
         end
      end
   end

   // pulses one descriptor, caller sits just after a rising edge
   task automatic queue_buffer(input qword_addr_t a, input qword_count_t n, input bit irq);
      for (int j = 0; j < n / 16; j++)
      begin
         exp_addr.push_back(a + qword_addr_t'(16 * j));
         exp_remain.push_back(n - qword_count_t'(16 * j));
         exp_irq.push_back(irq && (j == n / 16 - 1));
      end
      if (irq)
         test_irq_exp++;
      i_desc_valid = 1'b1;
      i_desc_addr = a;
      i_desc_count = n;
      i_desc_interrupt = irq;
      @(posedge clock);
      #1;
      i_desc_valid = 1'b0;
   endtask

   task automatic produce_words(input int n, input bit slow);
      integer     r;
      fifo_word_t w;
      bit         taken;
      @(posedge i_fifo_clock);
      #1;
      for (int sent = 0; sent < n; sent++)
      begin
         w = {$random(seed), $random(seed)};
         i_fifo_write = 1'b1;
         i_fifo_data = w;
         taken = 1'b0;
         while (!taken)
         begin
            @(negedge i_fifo_clock);
            taken = o_fifo_ready;   // ready only moves on the producer edge
            @(posedge i_fifo_clock);
         end
         words.push_back(w);
         #1;
         i_fifo_write = 1'b0;
         if (slow)
         begin
            r = $random(seed);
            repeat (r[1:0])
            begin
               @(posedge i_fifo_clock);
               #1;
            end
         end
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err0 = errors;
      test_irq0 = irq_count;
      test_irq_exp = 0;
      test_pkt0 = pkts_done;
   endtask

   task automatic finish_test();
      while (pkts_done < exp_addr.size())
         @(posedge clock);
      repeat (8) @(posedge clock);   // room for a late interrupt
      #1;
      if (irq_count - test_irq0 != test_irq_exp)
      begin
         $display("error %s interrupts expected %0d actual %0d", test_name, test_irq_exp,
                  irq_count - test_irq0);
         errors++;
      end
      if (o_status !== 32'd0)
      begin
         $display("error %s final status expected 0 actual %0d", test_name, o_status);
         errors++;
      end
      tests++;
      $display("test %s: %0d packets, %0d errors", test_name, pkts_done - test_pkt0,
               errors - test_err0);
   endtask

   initial
   begin
      seed = 91;
      cycles = 0;
      errors = 0;
      tests = 0;
      pkts_done = 0;
      irq_count = 0;
      in_pkt = 0;
      offer_seen = 0;
      rand_ready = 0;
      saw_full = 0;
      reset = 1'b1;
      i_fifo_write = 1'b0;
      i_fifo_data = '0;
      i_desc_valid = 1'b0;
      i_desc_addr = '0;
      i_desc_count = '0;
      i_desc_interrupt = 1'b0;
      i_wr_ready = 1'b0;
      repeat (2) @(posedge clock);
      #1;
      reset = 1'b0;
      repeat (10) @(posedge clock);   // producer reset synchronizer settles
      #1;

      start_test("addr32");
      queue_buffer(61'h0100_0000, 20'd32, 1'b0);
      produce_words(32, 1'b0);
      finish_test();

      start_test("addr64");
      queue_buffer(61'h2_0000_0100, 20'd32, 1'b0);
      produce_words(32, 1'b0);
      finish_test();

      start_test("queue_order");
      queue_buffer(61'h0000_2000, 20'd16, 1'b0);
      queue_buffer(61'h4_0000_0000, 20'd32, 1'b0);
      queue_buffer(61'h0000_3000, 20'd16, 1'b0);
      queue_buffer(61'h1_FFFF_FF00, 20'd16, 1'b0);
      queue_buffer(61'h0000_4000, 20'd32, 1'b0);
      @(negedge clock);
      if (o_desc_full !== 1'b1)
      begin
         $display("error %s desc_full expected 1 actual %0d", test_name, o_desc_full);
         errors++;
      end
      @(posedge clock);
      #1;
      produce_words(112, 1'b0);
      finish_test();

      start_test("interrupt");
      queue_buffer(61'h0000_8000, 20'd48, 1'b1);
      queue_buffer(61'h0000_9000, 20'd16, 1'b0);
      produce_words(64, 1'b0);
      finish_test();

      start_test("backpressure");
      rand_ready = 1;
      fork
         produce_words(96, 1'b1);
      join_none
      wait (saw_full);             // fifo filled with no buffer queued
      @(posedge clock);
      #1;
      queue_buffer(61'h3_0000_0000, 20'd64, 1'b1);
      queue_buffer(61'h0000_A000, 20'd32, 1'b0);
      finish_test();

      $display("tests %0d, packets %0d, interrupts %0d, errors %0d",
               tests, pkts_done, irq_count, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// ==== hififo_tpc_top.f ====
hififo_pkg.sv
hififo_fwft_fifo.sv
hififo_tpc_request.sv
hififo_tpc_writer.sv
hififo_tpc_top.sv
hififo_tpc_tb.sv

// ==== Makefile ====
# Verilator build and run of the host-bound bridge testbench

VERILATOR ?= verilator
TOP       ?= hififo_tpc_tb
FILELIST  ?= hififo_tpc_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
